// File: cpu4_pkg.sv
`default_nettype none

package cpu4_pkg;

  localparam int NIBBLE_W = 4;
  localparam int WORD_W = 12;

  typedef logic [NIBBLE_W-1:0] nibble_t;
  typedef logic [WORD_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] instr_t;

  // encoding of the r and q fields.
  typedef enum logic [1:0] {
    OPND_A  = 2'd0,
    OPND_B  = 2'd1,
    OPND_MX = 2'd2,
    OPND_MY = 2'd3
  } operand_e;

  typedef enum logic [1:0] {
    ALU_AND = 2'd0,
    ALU_OR  = 2'd1,
    ALU_XOR = 2'd2,
    ALU_ADD = 2'd3
  } alu_op_e;

  typedef enum logic [2:0] {
    INS_NOP,
    INS_LD_RI,
    INS_LD_X,
    INS_LD_Y,
    INS_ALU_RQ,
    INS_ALU_RI
  } instr_kind_e;

  typedef struct packed {
    logic carry;
    logic zero;
  } flags_t;

  localparam logic [2:0] LEN_SHORT = 3'd5;
  localparam logic [2:0] LEN_LONG = 3'd7;

  // opcode prefixes, matched against the top bits of the word.
  localparam logic [5:0] OPC_LD_RI = 6'b1110_00;
  localparam logic [3:0] OPC_LD_X = 4'b1011;
  localparam logic [3:0] OPC_LD_Y = 4'b1000;
  localparam logic [3:0] OPC_ALU_RQ = 4'b1010;
  localparam logic [2:0] OPC_ALU_RI = 3'b110;

endpackage

`default_nettype wire

// File: mem_if.sv
`default_nettype none

// one requester's port onto the shared data RAM.
interface mem_if;

  logic              req;
  logic              we;
  cpu4_pkg::addr_t   addr;
  cpu4_pkg::nibble_t wdata;
  cpu4_pkg::nibble_t rdata;

  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport arbiter (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: mem_array.sv
`default_nettype none

module mem_array #(
  parameter int ADDR_W = 12,
  parameter type word_t = logic [3:0]
) (
  input  logic            clk,
  input  logic            we,
  input  cpu4_pkg::addr_t addr,
  input  word_t           wdata,
  output word_t           rdata
);

  localparam int DEPTH = 1 << ADDR_W;

  word_t mem [0:DEPTH-1];
  logic [ADDR_W-1:0] index;

  assign index = addr[ADDR_W-1:0];

  // read returns the old word on a same-cycle write.
  always_ff @(posedge clk) begin
    if (we) begin
      mem[index] <= wdata;
    end
    rdata <= mem[index];
  end

endmodule

`default_nettype wire

// File: alu4.sv
`default_nettype none

module alu4 (
  input  cpu4_pkg::alu_op_e op,
  input  cpu4_pkg::nibble_t lhs,
  input  cpu4_pkg::nibble_t rhs,
  input  logic              carry_in,
  output cpu4_pkg::nibble_t result,
  output cpu4_pkg::flags_t  flags
);

  logic [4:0] sum;

  always_comb begin
    sum = {1'b0, lhs} + {1'b0, rhs};
    result = sum[3:0];
    flags.carry = carry_in;
    case (op)
      cpu4_pkg::ALU_AND: begin
        result = lhs & rhs;
      end
      cpu4_pkg::ALU_OR: begin
        result = lhs | rhs;
      end
      cpu4_pkg::ALU_XOR: begin
        result = lhs ^ rhs;
      end
      default: begin
        // carry out of the fifth bit of the sum.
        flags.carry = sum[4];
      end
    endcase
    flags.zero = (result == '0);
  end

endmodule

`default_nettype wire

// File: ram_arbiter.sv
`default_nettype none

module ram_arbiter (
  input  logic              clk,
  input  logic              rst,
  mem_if.arbiter            core,
  mem_if.arbiter            host,
  output logic              ram_we,
  output cpu4_pkg::addr_t   ram_addr,
  output cpu4_pkg::nibble_t ram_wdata,
  input  cpu4_pkg::nibble_t ram_rdata
);

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_CORE,
    OWN_HOST
  } owner_e;

  owner_e rd_owner;
  logic host_grant;

  // the core always wins, a host request waits on its bus.
  assign host_grant = host.req & ~core.req;

  always_comb begin
    if (core.req) begin
      ram_we = core.we;
      ram_addr = core.addr;
      ram_wdata = core.wdata;
    end else begin
      ram_we = host_grant & host.we;
      ram_addr = host.addr;
      ram_wdata = host.wdata;
    end
  end

  // remember who read so the data goes back to that side only.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_owner <= OWN_NONE;
    end else if (core.req && !core.we) begin
      rd_owner <= OWN_CORE;
    end else if (host_grant && !host.we) begin
      rd_owner <= OWN_HOST;
    end else begin
      rd_owner <= OWN_NONE;
    end
  end

  assign core.rdata = (rd_owner == OWN_CORE) ? ram_rdata : '0;
  assign host.rdata = (rd_owner == OWN_HOST) ? ram_rdata : '0;

  a_host_rdata_owner : assert property (@(posedge clk) disable iff (rst)
    !$past(host.req && !host.we && !core.req) |-> host.rdata == '0)
    else $error("read data returned to the host without a granted host read");

  a_core_rdata_owner : assert property (@(posedge clk) disable iff (rst)
    !$past(core.req && !core.we) |-> core.rdata == '0)
    else $error("read data returned to the core without a core read");

endmodule

`default_nettype wire

// File: cpu4_core.sv
`default_nettype none

module cpu4_core (
  input  logic              clk,
  input  logic              rst,
  input  logic              step,
  output logic              done,
  output logic              busy,
  output cpu4_pkg::addr_t   prog_addr,
  input  cpu4_pkg::instr_t  prog_data,
  mem_if.requester          mem,
  output cpu4_pkg::addr_t   pc,
  output cpu4_pkg::nibble_t reg_a,
  output cpu4_pkg::nibble_t reg_b,
  output cpu4_pkg::addr_t   reg_x,
  output cpu4_pkg::addr_t   reg_y,
  output cpu4_pkg::flags_t  flags
);

  logic [2:0] cnt;
  logic busy_q;
  cpu4_pkg::addr_t pc_q;
  cpu4_pkg::addr_t x_q;
  cpu4_pkg::addr_t y_q;
  cpu4_pkg::nibble_t a_q;
  cpu4_pkg::nibble_t b_q;
  cpu4_pkg::flags_t flags_q;
  cpu4_pkg::instr_t ir;
  cpu4_pkg::nibble_t lhs_mem;
  cpu4_pkg::nibble_t rhs_mem;

  cpu4_pkg::instr_kind_e kind;
  cpu4_pkg::alu_op_e op;
  cpu4_pkg::operand_e dst;
  cpu4_pkg::operand_e src;
  logic [2:0] len;
  cpu4_pkg::nibble_t imm;
  cpu4_pkg::nibble_t lhs;
  cpu4_pkg::nibble_t rhs;
  cpu4_pkg::nibble_t alu_result;
  cpu4_pkg::nibble_t wb_data;
  cpu4_pkg::flags_t alu_flags;
  logic start;
  logic uses_alu;
  logic dst_is_mem;
  logic src_is_mem;

  function automatic cpu4_pkg::nibble_t operand_value(
    input cpu4_pkg::operand_e sel,
    input cpu4_pkg::nibble_t  a_val,
    input cpu4_pkg::nibble_t  b_val,
    input cpu4_pkg::nibble_t  m_val
  );
    case (sel)
      cpu4_pkg::OPND_A: return a_val;
      cpu4_pkg::OPND_B: return b_val;
      default: return m_val;
    endcase
  endfunction

  // decoder, valid from cycle 3 once ir holds the fetched word.
  always_comb begin
    kind = cpu4_pkg::INS_NOP;
    op = cpu4_pkg::ALU_ADD;
    dst = cpu4_pkg::operand_e'(ir[5:4]);
    src = cpu4_pkg::operand_e'(ir[1:0]);
    imm = ir[3:0];
    if (ir[11:6] == cpu4_pkg::OPC_LD_RI) begin
      kind = cpu4_pkg::INS_LD_RI;
    end else if (ir[11:8] == cpu4_pkg::OPC_LD_X) begin
      kind = cpu4_pkg::INS_LD_X;
    end else if (ir[11:8] == cpu4_pkg::OPC_LD_Y) begin
      kind = cpu4_pkg::INS_LD_Y;
    end else if (ir[11:8] == cpu4_pkg::OPC_ALU_RQ) begin
      dst = cpu4_pkg::operand_e'(ir[3:2]);
      kind = cpu4_pkg::INS_ALU_RQ;
      case (ir[7:4])
        4'h8: op = cpu4_pkg::ALU_ADD;
        4'hc: op = cpu4_pkg::ALU_AND;
        4'hd: op = cpu4_pkg::ALU_OR;
        4'he: op = cpu4_pkg::ALU_XOR;
        default: kind = cpu4_pkg::INS_NOP;
      endcase
    end else if (ir[11:9] == cpu4_pkg::OPC_ALU_RI) begin
      kind = cpu4_pkg::INS_ALU_RI;
      case (ir[8:6])
        3'b000: op = cpu4_pkg::ALU_ADD;
        3'b010: op = cpu4_pkg::ALU_AND;
        3'b011: op = cpu4_pkg::ALU_OR;
        3'b100: op = cpu4_pkg::ALU_XOR;
        default: kind = cpu4_pkg::INS_NOP;
      endcase
    end
    uses_alu = (kind == cpu4_pkg::INS_ALU_RQ) || (kind == cpu4_pkg::INS_ALU_RI);
    len = uses_alu ? cpu4_pkg::LEN_LONG : cpu4_pkg::LEN_SHORT;
  end

  assign dst_is_mem = (dst == cpu4_pkg::OPND_MX) || (dst == cpu4_pkg::OPND_MY);
  assign src_is_mem = (src == cpu4_pkg::OPND_MX) || (src == cpu4_pkg::OPND_MY);

  assign lhs = operand_value(dst, a_q, b_q, lhs_mem);
  assign rhs = (kind == cpu4_pkg::INS_ALU_RI) ? imm : operand_value(src, a_q, b_q, rhs_mem);

  alu4 u_alu (
    .op       (op),
    .lhs      (lhs),
    .rhs      (rhs),
    .carry_in (flags_q.carry),
    .result   (alu_result),
    .flags    (alu_flags)
  );

  assign wb_data = (kind == cpu4_pkg::INS_LD_RI) ? imm : alu_result;
  assign start = step & ~busy_q;
  assign done = busy_q && (cnt == len);

  // r is read in cycle 3, a memory q in cycle 4, the write lands with done.
  always_comb begin
    mem.req = 1'b0;
    mem.we = 1'b0;
    mem.addr = x_q;
    mem.wdata = wb_data;
    if (busy_q && cnt == 3'd3 && uses_alu && dst_is_mem) begin
      mem.req = 1'b1;
      mem.addr = (dst == cpu4_pkg::OPND_MY) ? y_q : x_q;
    end else if (busy_q && cnt == 3'd4 && kind == cpu4_pkg::INS_ALU_RQ && src_is_mem) begin
      mem.req = 1'b1;
      mem.addr = (src == cpu4_pkg::OPND_MY) ? y_q : x_q;
    end else if (done && dst_is_mem && (uses_alu || kind == cpu4_pkg::INS_LD_RI)) begin
      mem.req = 1'b1;
      mem.we = 1'b1;
      mem.addr = (dst == cpu4_pkg::OPND_MY) ? y_q : x_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      cnt <= 3'd0;
      pc_q <= '0;
      a_q <= '0;
      b_q <= '0;
      x_q <= '0;
      y_q <= '0;
      flags_q <= '0;
    end else if (start) begin
      busy_q <= 1'b1;
      cnt <= 3'd1;
    end else if (done) begin
      busy_q <= 1'b0;
      cnt <= 3'd0;
      pc_q <= pc_q + 1'b1;
      if (uses_alu) begin
        flags_q <= alu_flags;
      end
      if (uses_alu || kind == cpu4_pkg::INS_LD_RI) begin
        if (dst == cpu4_pkg::OPND_A) begin
          a_q <= wb_data;
        end else if (dst == cpu4_pkg::OPND_B) begin
          b_q <= wb_data;
        end
      end
      // e loads the low byte, the page bits stay.
      if (kind == cpu4_pkg::INS_LD_X) begin
        x_q[7:0] <= ir[7:0];
      end
      if (kind == cpu4_pkg::INS_LD_Y) begin
        y_q[7:0] <= ir[7:0];
      end
    end else if (busy_q) begin
      cnt <= cnt + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (busy_q && cnt == 3'd2) begin
      ir <= prog_data;
    end
    if (busy_q && cnt == 3'd4) begin
      lhs_mem <= mem.rdata;
    end
    if (busy_q && cnt == 3'd5) begin
      rhs_mem <= mem.rdata;
    end
  end

  assign busy = busy_q;
  assign prog_addr = pc_q;
  assign pc = pc_q;
  assign reg_a = a_q;
  assign reg_b = b_q;
  assign reg_x = x_q;
  assign reg_y = y_q;
  assign flags = flags_q;

  a_no_step_when_busy : assert property (@(posedge clk) disable iff (rst)
    step |-> !busy_q)
    else $error("step arrived while an instruction was still running");

endmodule

`default_nettype wire

// File: cpu4_top.sv
`default_nettype none

module cpu4_top #(
  parameter int ADDR_W = 12
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              step,
  output logic              done,
  output logic              busy,
  input  logic              prog_we,
  input  cpu4_pkg::addr_t   prog_addr,
  input  cpu4_pkg::instr_t  prog_data,
  input  logic              host_ram_we,
  input  logic              host_ram_re,
  input  cpu4_pkg::addr_t   host_ram_addr,
  input  cpu4_pkg::nibble_t host_ram_wdata,
  output cpu4_pkg::nibble_t host_ram_rdata,
  output logic              host_ram_rvalid,
  output cpu4_pkg::addr_t   pc,
  output cpu4_pkg::nibble_t reg_a,
  output cpu4_pkg::nibble_t reg_b,
  output cpu4_pkg::addr_t   reg_x,
  output cpu4_pkg::addr_t   reg_y,
  output logic              carry,
  output logic              zero
);

  mem_if core_bus ();
  mem_if host_bus ();

  cpu4_pkg::addr_t core_fetch_addr;
  cpu4_pkg::addr_t pmem_addr;
  cpu4_pkg::instr_t pmem_rdata;
  cpu4_pkg::flags_t flags;
  logic ram_we;
  cpu4_pkg::addr_t ram_addr;
  cpu4_pkg::nibble_t ram_wdata;
  cpu4_pkg::nibble_t ram_rdata;
  logic host_grant;
  logic host_take;
  logic rvalid_q;

  cpu4_core u_core (
    .clk       (clk),
    .rst       (rst),
    .step      (step),
    .done      (done),
    .busy      (busy),
    .prog_addr (core_fetch_addr),
    .prog_data (pmem_rdata),
    .mem       (core_bus.requester),
    .pc        (pc),
    .reg_a     (reg_a),
    .reg_b     (reg_b),
    .reg_x     (reg_x),
    .reg_y     (reg_y),
    .flags     (flags)
  );

  ram_arbiter u_arb (
    .clk       (clk),
    .rst       (rst),
    .core      (core_bus.arbiter),
    .host      (host_bus.arbiter),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata)
  );

  mem_array #(
    .ADDR_W (ADDR_W),
    .word_t (cpu4_pkg::nibble_t)
  ) u_ram (
    .clk   (clk),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  // host owns the program memory while the core is idle.
  assign pmem_addr = busy ? core_fetch_addr : prog_addr;

  mem_array #(
    .ADDR_W (ADDR_W),
    .word_t (cpu4_pkg::instr_t)
  ) u_pmem (
    .clk   (clk),
    .we    (prog_we & ~busy),
    .addr  (pmem_addr),
    .wdata (prog_data),
    .rdata (pmem_rdata)
  );

  assign host_grant = host_bus.req & ~core_bus.req;
  assign host_take = (host_ram_we | host_ram_re) & (~host_bus.req | host_grant);

  // a host request stays captured until the core leaves a free cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      host_bus.req <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= host_grant & ~host_bus.we;
      if (host_take) begin
        host_bus.req <= 1'b1;
      end else if (host_grant) begin
        host_bus.req <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (host_take) begin
      host_bus.we <= host_ram_we;
      host_bus.addr <= host_ram_addr;
      host_bus.wdata <= host_ram_wdata;
    end
  end

  assign host_ram_rdata = host_bus.rdata;
  assign host_ram_rvalid = rvalid_q;
  assign carry = flags.carry;
  assign zero = flags.zero;

endmodule

`default_nettype wire

// File: cpu4_tb.sv
`default_nettype none

module cpu4_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_ROWS = 18;
  localparam int N_RAND = 24;
  localparam int LOAD_CYCLES = 32;
  localparam int LIMIT = (N_ROWS + N_RAND) * 7 + (N_ROWS + N_RAND + 2) * LOAD_CYCLES + 200;

  typedef struct {
    cpu4_pkg::instr_t  ins;
    cpu4_pkg::nibble_t init_x;
    cpu4_pkg::nibble_t init_y;
    cpu4_pkg::nibble_t exp_a;
    cpu4_pkg::nibble_t exp_b;
    cpu4_pkg::addr_t   exp_x;
    cpu4_pkg::addr_t   exp_y;
    logic              exp_c;
    logic              exp_z;
    cpu4_pkg::nibble_t exp_mx;
    cpu4_pkg::nibble_t exp_my;
    int                len;
  } row_t;

  logic clk;
  logic rst;
  logic step;
  logic done;
  logic busy;
  logic prog_we;
  cpu4_pkg::addr_t prog_addr;
  cpu4_pkg::instr_t prog_data;
  logic host_ram_we;
  logic host_ram_re;
  cpu4_pkg::addr_t host_ram_addr;
  cpu4_pkg::nibble_t host_ram_wdata;
  cpu4_pkg::nibble_t host_ram_rdata;
  logic host_ram_rvalid;
  cpu4_pkg::addr_t pc;
  cpu4_pkg::nibble_t reg_a;
  cpu4_pkg::nibble_t reg_b;
  cpu4_pkg::addr_t reg_x;
  cpu4_pkg::addr_t reg_y;
  logic carry;
  logic zero;

  row_t rows[$];
  int cycle_count;
  logic [19:0] lfsr;
  cpu4_pkg::nibble_t exp_a;
  cpu4_pkg::nibble_t exp_b;
  cpu4_pkg::addr_t exp_x;
  cpu4_pkg::addr_t exp_y;
  cpu4_pkg::addr_t exp_pc;
  logic exp_c;

  cpu4_top #(.ADDR_W(12)) UUT (
    .clk             (clk),
    .rst             (rst),
    .step            (step),
    .done            (done),
    .busy            (busy),
    .prog_we         (prog_we),
    .prog_addr       (prog_addr),
    .prog_data       (prog_data),
    .host_ram_we     (host_ram_we),
    .host_ram_re     (host_ram_re),
    .host_ram_addr   (host_ram_addr),
    .host_ram_wdata  (host_ram_wdata),
    .host_ram_rdata  (host_ram_rdata),
    .host_ram_rvalid (host_ram_rvalid),
    .pc              (pc),
    .reg_a           (reg_a),
    .reg_b           (reg_b),
    .reg_x           (reg_x),
    .reg_y           (reg_y),
    .carry           (carry),
    .zero            (zero)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= LIMIT) begin
      $display("done never came, the run passed its cycle limit of %0d", LIMIT);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic check_nibble(input string name, input cpu4_pkg::nibble_t exp,
                              input cpu4_pkg::nibble_t act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "nibble mismatch");
    end
  endtask

  task automatic check_addr(input string name, input cpu4_pkg::addr_t exp,
                            input cpu4_pkg::addr_t act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_flags(input string name, input cpu4_pkg::flags_t exp,
                             input cpu4_pkg::flags_t act);
    if (exp !== act) begin
      $display("ERR %s expected c=%b z=%b actual c=%b z=%b", name, exp.carry, exp.zero,
               act.carry, act.zero);
      $display("STATUS: FAIL");
      $fatal(1, "flags mismatch");
    end
  endtask

  task automatic check_len(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("ERR %s expected %0d actual %0d", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "length mismatch");
    end
  endtask

  // 20-bit fibonacci register, taps 20 and 17.
  function automatic logic [19:0] lfsr_next(input logic [19:0] s);
    return {s[18:0], s[19] ^ s[16]};
  endfunction

  task automatic rand_bits(input int n, output logic [3:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[2:0], lfsr[0]};
    end
  endtask

  // returns {carry, result}.
  function automatic logic [4:0] alu_model(input cpu4_pkg::alu_op_e op,
                                           input cpu4_pkg::nibble_t l,
                                           input cpu4_pkg::nibble_t r, input logic cin);
    case (op)
      cpu4_pkg::ALU_AND: return {cin, l & r};
      cpu4_pkg::ALU_OR: return {cin, l | r};
      cpu4_pkg::ALU_XOR: return {cin, l ^ r};
      default: return {1'b0, l} + {1'b0, r};
    endcase
  endfunction

  function automatic cpu4_pkg::instr_t encode_alu(input logic ri, input cpu4_pkg::alu_op_e op,
                                                  input logic [1:0] r, input logic [1:0] q,
                                                  input cpu4_pkg::nibble_t imm);
    logic [3:0] rq_op;
    logic [2:0] ri_op;
    case (op)
      cpu4_pkg::ALU_AND: begin
        rq_op = 4'hc;
        ri_op = 3'b010;
      end
      cpu4_pkg::ALU_OR: begin
        rq_op = 4'hd;
        ri_op = 3'b011;
      end
      cpu4_pkg::ALU_XOR: begin
        rq_op = 4'he;
        ri_op = 3'b100;
      end
      default: begin
        rq_op = 4'h8;
        ri_op = 3'b000;
      end
    endcase
    if (ri) begin
      return {3'b110, ri_op, r, imm};
    end
    return {4'b1010, rq_op, r, q};
  endfunction

  function automatic cpu4_pkg::nibble_t pick(input logic [1:0] s, input cpu4_pkg::nibble_t mx,
                                             input cpu4_pkg::nibble_t my);
    case (s)
      2'd0: return exp_a;
      2'd1: return exp_b;
      2'd2: return mx;
      default: return my;
    endcase
  endfunction

  task automatic load_instr(input cpu4_pkg::addr_t addr, input cpu4_pkg::instr_t ins);
    @(posedge clk);
    prog_we <= 1'b1;
    prog_addr <= addr;
    prog_data <= ins;
    @(posedge clk);
    prog_we <= 1'b0;
  endtask

  task automatic ram_write(input cpu4_pkg::addr_t addr, input cpu4_pkg::nibble_t val);
    @(posedge clk);
    host_ram_we <= 1'b1;
    host_ram_addr <= addr;
    host_ram_wdata <= val;
    @(posedge clk);
    host_ram_we <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic ram_read(input cpu4_pkg::addr_t addr, output cpu4_pkg::nibble_t val);
    @(posedge clk);
    host_ram_re <= 1'b1;
    host_ram_addr <= addr;
    @(posedge clk);
    host_ram_re <= 1'b0;
    @(negedge clk);
    while (!host_ram_rvalid) begin
      @(negedge clk);
    end
    val = host_ram_rdata;
  endtask

  // counts cycles from the step being taken until done.
  task automatic wait_done(output int n);
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (!busy) begin
        $display("busy was low in cycle %0d of a running instruction", n);
        $display("STATUS: FAIL");
        $fatal(1, "busy low");
      end
    end while (!done);
    @(posedge clk);
    @(negedge clk);
    if (done || busy) begin
      $display("done or busy stayed high after the instruction ended");
      $display("STATUS: FAIL");
      $fatal(1, "busy high");
    end
  endtask

  task automatic exec_and_check(input string name, input row_t r);
    int n;
    cpu4_pkg::nibble_t v;
    cpu4_pkg::addr_t ox;
    cpu4_pkg::addr_t oy;
    ox = exp_x;
    oy = exp_y;
    load_instr(exp_pc, r.ins);
    ram_write(ox, r.init_x);
    ram_write(oy, r.init_y);
    @(posedge clk);
    step <= 1'b1;
    @(posedge clk);
    step <= 1'b0;
    wait_done(n);
    exp_pc = exp_pc + 12'd1;
    check_len({name, " len"}, r.len, n);
    check_addr({name, " pc"}, exp_pc, pc);
    check_nibble({name, " a"}, r.exp_a, reg_a);
    check_nibble({name, " b"}, r.exp_b, reg_b);
    check_addr({name, " x"}, r.exp_x, reg_x);
    check_addr({name, " y"}, r.exp_y, reg_y);
    check_flags({name, " flags"}, '{carry: r.exp_c, zero: r.exp_z}, '{carry: carry, zero: zero});
    ram_read(ox, v);
    check_nibble({name, " m(x)"}, r.exp_mx, v);
    ram_read(oy, v);
    check_nibble({name, " m(y)"}, r.exp_my, v);
    exp_a = r.exp_a;
    exp_b = r.exp_b;
    exp_x = r.exp_x;
    exp_y = r.exp_y;
    exp_c = r.exp_c;
  endtask

  task automatic add_row(input cpu4_pkg::instr_t ins, input cpu4_pkg::nibble_t ix,
                         input cpu4_pkg::nibble_t iy, input cpu4_pkg::nibble_t a,
                         input cpu4_pkg::nibble_t b, input cpu4_pkg::addr_t x,
                         input cpu4_pkg::addr_t y, input logic c, input logic z,
                         input cpu4_pkg::nibble_t mx, input cpu4_pkg::nibble_t my, input int len);
    row_t r;
    r = '{ins, ix, iy, a, b, x, y, c, z, mx, my, len};
    rows.push_back(r);
  endtask

  task automatic build_table();
    // ins, init m(x), init m(y), a, b, x, y, c, z, m(x), m(y), cycles.
    add_row(12'hb35, 4'h0, 4'h0, 4'h0, 4'h0, 12'h035, 12'h000, 0, 0, 4'h0, 4'h0, 5);
    add_row(12'h85a, 4'h3, 4'h9, 4'h0, 4'h0, 12'h035, 12'h05a, 0, 0, 4'h3, 4'h9, 5);
    add_row(12'he07, 4'hc, 4'h6, 4'h7, 4'h0, 12'h035, 12'h05a, 0, 0, 4'hc, 4'h6, 5);
    add_row(12'he1c, 4'h1, 4'h2, 4'h7, 4'hc, 12'h035, 12'h05a, 0, 0, 4'h1, 4'h2, 5);
    add_row(12'he25, 4'hf, 4'h4, 4'h7, 4'hc, 12'h035, 12'h05a, 0, 0, 4'h5, 4'h4, 5);
    add_row(12'he3a, 4'h1, 4'h2, 4'h7, 4'hc, 12'h035, 12'h05a, 0, 0, 4'h1, 4'ha, 5);
    add_row(12'hac1, 4'h3, 4'h3, 4'h4, 4'hc, 12'h035, 12'h05a, 0, 0, 4'h3, 4'h3, 7);
    add_row(12'ha82, 4'hd, 4'h0, 4'h1, 4'hc, 12'h035, 12'h05a, 1, 0, 4'hd, 4'h0, 7);
    add_row(12'hcd3, 4'h5, 4'h6, 4'h1, 4'hf, 12'h035, 12'h05a, 1, 0, 4'h5, 4'h6, 7);
    add_row(12'haec, 4'h2, 4'h1, 4'h1, 4'hf, 12'h035, 12'h05a, 1, 1, 4'h2, 4'h0, 7);
    add_row(12'hacb, 4'he, 4'h7, 4'h1, 4'hf, 12'h035, 12'h05a, 1, 0, 4'h6, 4'h7, 7);
    add_row(12'hc11, 4'h0, 4'h0, 4'h1, 4'h0, 12'h035, 12'h05a, 1, 1, 4'h0, 4'h0, 7);
    add_row(12'hc03, 4'h9, 4'h8, 4'h4, 4'h0, 12'h035, 12'h05a, 0, 0, 4'h9, 4'h8, 7);
    add_row(12'hd04, 4'h0, 4'h0, 4'h0, 4'h0, 12'h035, 12'h05a, 0, 1, 4'h0, 4'h0, 7);
    add_row(12'h000, 4'h5, 4'h6, 4'h0, 4'h0, 12'h035, 12'h05a, 0, 1, 4'h5, 4'h6, 5);
    add_row(12'ha89, 4'hf, 4'h1, 4'h0, 4'h0, 12'h035, 12'h05a, 0, 0, 4'hf, 4'h1, 7);
    add_row(12'hcf0, 4'h2, 4'h0, 4'h0, 4'h0, 12'h035, 12'h05a, 0, 1, 4'h2, 4'h0, 7);
    add_row(12'hf00, 4'h3, 4'h4, 4'h0, 4'h0, 12'h035, 12'h05a, 0, 1, 4'h3, 4'h4, 5);
  endtask

  initial begin
    int n;
    row_t r;
    logic [3:0] f;
    logic [3:0] o;
    logic [3:0] rs;
    logic [3:0] qs;
    logic [3:0] im;
    logic [3:0] mx0;
    logic [3:0] my0;
    logic [4:0] res;
    cpu4_pkg::nibble_t v;
    clk = 1'b0;
    rst = 1'b1;
    step = 1'b0;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    host_ram_we = 1'b0;
    host_ram_re = 1'b0;
    host_ram_addr = '0;
    host_ram_wdata = '0;
    cycle_count = 0;
    lfsr = 20'd82072;
    exp_a = '0;
    exp_b = '0;
    exp_x = '0;
    exp_y = '0;
    exp_pc = '0;
    exp_c = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (done || busy || host_ram_rvalid) begin
      $display("done, busy or host_ram_rvalid was high after reset");
      $display("STATUS: FAIL");
      $fatal(1, "reset state");
    end
    check_addr("reset pc", 12'h000, pc);
    check_nibble("reset a", 4'h0, reg_a);
    check_nibble("reset b", 4'h0, reg_b);
    check_addr("reset x", 12'h000, reg_x);
    check_addr("reset y", 12'h000, reg_y);
    check_flags("reset flags", '{carry: 1'b0, zero: 1'b0}, '{carry: carry, zero: zero});

    build_table();
    foreach (rows[i]) begin
      exec_and_check($sformatf("row%0d", i), rows[i]);
    end

    for (int k = 0; k < N_RAND; k++) begin
      rand_bits(1, f);
      rand_bits(2, o);
      rand_bits(2, rs);
      rand_bits(2, qs);
      rand_bits(4, im);
      rand_bits(4, mx0);
      rand_bits(4, my0);
      res = alu_model(cpu4_pkg::alu_op_e'(o[1:0]), pick(rs[1:0], mx0, my0),
                      f[0] ? im : pick(qs[1:0], mx0, my0), exp_c);
      r = '{encode_alu(f[0], cpu4_pkg::alu_op_e'(o[1:0]), rs[1:0], qs[1:0], im),
            mx0, my0, exp_a, exp_b, exp_x, exp_y, res[4], res[3:0] == 4'h0, mx0, my0, 7};
      case (rs[1:0])
        2'd0: r.exp_a = res[3:0];
        2'd1: r.exp_b = res[3:0];
        2'd2: r.exp_mx = res[3:0];
        default: r.exp_my = res[3:0];
      endcase
      exec_and_check($sformatf("rand%0d", k), r);
    end

    // a host write issued while the core reads m(x) waits for a free cycle.
    ram_write(exp_x, 4'h6);
    load_instr(exp_pc, encode_alu(1'b0, cpu4_pkg::ALU_ADD, 2'd2, 2'd2, 4'h0));
    @(posedge clk);
    step <= 1'b1;
    @(posedge clk);
    step <= 1'b0;
    @(posedge clk);
    host_ram_we <= 1'b1;
    host_ram_addr <= 12'h100;
    host_ram_wdata <= 4'h9;
    @(posedge clk);
    host_ram_we <= 1'b0;
    wait_done(n);
    exp_pc = exp_pc + 12'd1;
    check_len("busy write len", 7, n + 2);
    check_addr("busy write pc", exp_pc, pc);
    check_flags("busy write flags", '{carry: 1'b0, zero: 1'b0}, '{carry: carry, zero: zero});
    ram_read(exp_x, v);
    check_nibble("busy write m(x)", 4'hc, v);
    ram_read(12'h100, v);
    check_nibble("busy write m", 4'h9, v);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: cpu4_top.f
cpu4_pkg.sv
mem_if.sv
mem_array.sv
alu4.sv
ram_arbiter.sv
cpu4_core.sv
cpu4_top.sv
cpu4_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP := cpu4_tb
FILELIST := cpu4_top.f
OBJ_DIR := obj_dir
SIM := $(OBJ_DIR)/V$(TOP)
LOG := sim.log
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
